// ==== build.f ====
+incdir+test
src/rv_pkg.sv
src/fetch_unit.sv
src/inst_decoder.sv
src/reg_file.sv
src/alu.sv
src/execute_unit.sv
src/mem_wb_unit.sv
src/core_top.sv
test/core_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module core_tb -o core_tb_sim \
    && ./obj_dir/core_tb_sim \
    || exit 1

// ==== test/ref_model.svh ====
/* rv32i reference model */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// architectural state of the reference copy
word_t ref_pc;
word_t ref_regs [32];
word_t ref_dmem [64];

// every byte of the data area starts as a function of its own address
function automatic word_t dmem_fill(int n);
    return {8'(4 * n + 3), 8'(4 * n + 2), 8'(4 * n + 1), 8'(4 * n)} ^ 32'h5a5a_a5a5;
endfunction

function automatic void ref_reset();
    ref_pc = reset_pc;
    for (int n = 0; n < 32; n++) begin
        ref_regs[n] = '0;
    end
    for (int n = 0; n < 64; n++) begin
        ref_dmem[n] = dmem_fill(n);
    end
endfunction

function automatic word_t ref_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: return (a < b) ? 32'd1 : 32'd0;
        3'd4: return a ^ b;
        3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_taken(logic [2:0] f3, word_t a, word_t b);
    case (f3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        3'd7: return a >= b;
        default: return 1'b0;
    endcase
endfunction

// one instruction on the reference state
function automatic void ref_step(input word_t w, output retire_t r, output dmem_req_t req);
    logic [2:0] f3;
    reg_addr_t  rd;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      addr;
    word_t      lane;
    int         nbytes;
    f3    = w[14:12];
    rd    = w[11:7];
    a     = ref_regs[w[19:15]];
    b     = ref_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    r.pc      = ref_pc;
    r.rd      = rd;
    r.we      = 1'b0;
    r.wdata   = '0;
    r.next_pc = ref_pc + 32'd4;
    req       = '0;
    case (w[6:0])
        7'b0110011: begin
            r.we    = 1'b1;
            r.wdata = ref_alu(f3, w[30], a, b);
        end
        7'b0010011: begin
            r.we    = 1'b1;
            r.wdata = ref_alu(f3, f3 == 3'd5 && w[30], a, imm_i);  // no subi
        end
        7'b0110111: begin
            r.we    = 1'b1;
            r.wdata = {w[31:12], 12'h000};
        end
        7'b0010111: begin
            r.we    = 1'b1;
            r.wdata = ref_pc + {w[31:12], 12'h000};
        end
        7'b1101111: begin
            r.we      = 1'b1;
            r.wdata   = ref_pc + 32'd4;
            r.next_pc = ref_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        7'b1100111: begin
            r.we      = 1'b1;
            r.wdata   = ref_pc + 32'd4;
            r.next_pc = (a + imm_i) & ~32'd1;
        end
        7'b1100011: begin
            if (branch_taken(f3, a, b)) begin
                r.next_pc = ref_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
        end
        7'b0000011: begin
            addr    = a + imm_i;
            lane    = ref_dmem[addr[7:2]] >> (8 * addr[1:0]);
            r.we    = 1'b1;
            case (f3)
                3'd0: r.wdata = {{24{lane[7]}}, lane[7:0]};
                3'd1: r.wdata = {{16{lane[15]}}, lane[15:0]};
                3'd4: r.wdata = {24'h0, lane[7:0]};
                3'd5: r.wdata = {16'h0, lane[15:0]};
                default: r.wdata = lane;
            endcase
        end
        7'b0100011: begin
            addr      = a + {{20{w[31]}}, w[31:25], w[11:7]};
            nbytes    = 1 << f3[1:0];
            req.addr  = addr;
            req.wdata = b << (8 * addr[1:0]);
            for (int k = 0; k < 4; k++) begin
                req.wmask[k] = (k >= int'(addr[1:0])) && (k < int'(addr[1:0]) + nbytes);
                if (req.wmask[k]) begin
                    ref_dmem[addr[7:2]][8 * k +: 8] = req.wdata[8 * k +: 8];
                end
            end
        end
        default: ;  // system and unknown opcodes do nothing
    endcase
    if (r.we && rd != 5'd0) begin
        ref_regs[rd] = r.wdata;
    end
    ref_pc = r.next_pc;
endfunction

function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};  // good high bits go low
endfunction

function automatic int lcg_pick(int n);
    return int'(lcg_next() % 32'(n));
endfunction

function automatic reg_addr_t pick_rd();
    if (lcg_pick(16) == 0) begin
        return 5'd0;
    end
    return 5'(1 + lcg_pick(30));  // x31 stays with the jalr sequences
endfunction

function automatic void gen_program();
    int          i;
    int          kind;
    int          off;
    word_t       rnd;
    logic [2:0]  f3;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [11:0] imm;
    logic [20:0] jimm;
    bit          is_target [512];
    for (int k = 0; k < 512; k++) begin
        is_target[k] = 1'b0;
    end
    i = 0;
    while (i < 512) begin
        rnd  = lcg_next();
        f3   = 3'(lcg_pick(8));
        rd   = pick_rd();
        rs1  = 5'(lcg_pick(32));
        rs2  = 5'(lcg_pick(32));
        kind = lcg_pick(16);
        if (kind == 13 && (i + 1 >= 512 || is_target[i + 1])) begin
            kind = 0;  // a jalr must never be entered without its auipc
        end
        case (kind)
            4, 5, 6: begin
                imm = rnd[11:0];
                if (f3 == 3'd1) begin
                    imm = {7'h00, rnd[4:0]};
                end else if (f3 == 3'd5) begin
                    imm = {rnd[20] ? 7'h20 : 7'h00, rnd[4:0]};
                end
                prog[i] = {imm, rs1, f3, rd, 7'b0010011};
            end
            7: prog[i] = {rnd[31:12], rd, 7'b0110111};
            8: prog[i] = {rnd[31:12], rd, 7'b0010111};
            9, 10: begin
                if (kind == 10) begin
                    f3 = 3'(lcg_pick(3));
                end else if (f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7) begin
                    f3 = 3'd2;
                end
                off = lcg_pick(256);
                off = off - off % (1 << f3[1:0]);  // natural alignment
                imm = 12'(off);
                if (kind == 9) begin
                    prog[i] = {imm, 5'd0, f3, rd, 7'b0000011};
                end else begin
                    prog[i] = {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
                end
            end
            11, 12: begin
                off  = 4 * (1 + lcg_pick(4));
                jimm = 21'(off);
                if (i + off / 4 < 512) begin
                    is_target[i + off / 4] = 1'b1;
                end
                if (f3 == 3'd2 || f3 == 3'd3) begin
                    f3 = f3 + 3'd2;
                end
                if (kind == 11) begin
                    prog[i] = {jimm[12], jimm[10:5], rs2, rs1, f3, jimm[4:1], jimm[11],
                               7'b1100011};
                end else begin
                    prog[i] = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], rd, 7'b1101111};
                end
            end
            13: begin
                off = 8 + 4 * lcg_pick(4) + int'(rnd[3]);  // odd offsets test bit 0
                prog[i]     = {20'h00000, 5'd31, 7'b0010111};
                prog[i + 1] = {12'(off), 5'd31, 3'b000, rd, 7'b1100111};
                if (i + off / 4 < 512) begin
                    is_target[i + off / 4] = 1'b1;
                end
                i++;
            end
            14: prog[i] = rnd[0] ? {rnd[31:7], 7'b1110011} : {rnd[31:7], 7'b0001011};
            default: begin
                prog[i] = {((f3 == 3'd0 || f3 == 3'd5) && rnd[12]) ? 7'h20 : 7'h00,
                           rs2, rs1, f3, rd, 7'b0110011};
            end
        endcase
        i++;
    end
endfunction

`endif

// ==== test/core_tb.sv ====
/* rv32i core testbench */

module core_tb;
    import rv_pkg::*;

    localparam word_t reset_pc    = 32'h8000_0000;
    localparam int    num_retires = 300;
    localparam int    cycle_limit = 2 * num_retires + 8 + 20;

    logic      clk;
    logic      reset;
    word_t     imem_addr;
    word_t     imem_rdata;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;
    logic      retire_valid;
    retire_t   retire;

    word_t       prog [512];
    word_t       dut_dmem [64];
    logic [31:0] lcg_state;
    int          cycles;
    int          retires;
    logic        expect_exec;

    `include "ref_model.svh"

    core_top #(
        .reset_pc (reset_pc)
    ) dut_i (
        .clk          (clk),
        .reset        (reset),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .dmem_req     (dmem_req),
        .dmem_rdata   (dmem_rdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    // past the program the core only sees addi x0, x0, 0
    function automatic word_t fetch_word(word_t addr);
        word_t idx;
        idx = (addr - reset_pc) >> 2;
        if (addr >= reset_pc && idx < 32'd512) begin
            return prog[idx[8:0]];
        end
        return 32'h0000_0013;
    endfunction

    task automatic check_word(input string what, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    // both memories answer in the same cycle
    assign imem_rdata = fetch_word(imem_addr);
    assign dmem_rdata = dut_dmem[dmem_req.addr[7:2]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        reset     = 1'b1;
        lcg_state = 32'hdff6;
        gen_program();
        repeat (8) @(posedge clk);
        #5 reset = 1'b0;
    end

    always @(posedge clk) begin
        if (reset) begin
            for (int n = 0; n < 64; n++) begin
                dut_dmem[n] <= dmem_fill(n);
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_req.wmask[b]) begin
                    dut_dmem[dmem_req.addr[7:2]][8 * b +: 8] <= dmem_req.wdata[8 * b +: 8];
                end
            end
        end
    end

    // compare at the falling edge in mid cycle
    always @(negedge clk) begin
        retire_t   exp_ret;
        dmem_req_t exp_req;
        if (reset) begin
            ref_reset();
            expect_exec = 1'b0;  // first cycle after reset fetches
            retires     = 0;
            check_word("retire_valid in reset", 32'(retire_valid), 32'd0);
            check_word("wmask in reset", 32'(dmem_req.wmask), 32'd0);
        end else begin
            check_word("retire_valid", 32'(retire_valid), 32'(expect_exec));
            expect_exec = ~expect_exec;
            if (retire_valid) begin
                ref_step(fetch_word(ref_pc), exp_ret, exp_req);
                check_word("retire pc", retire.pc, exp_ret.pc);
                check_word("retire we", 32'(retire.we), 32'(exp_ret.we));
                if (exp_ret.we) begin
                    check_word("retire rd", 32'(retire.rd), 32'(exp_ret.rd));
                    check_word("retire wdata", retire.wdata, exp_ret.wdata);
                end
                check_word("retire next_pc", retire.next_pc, exp_ret.next_pc);
                check_word("store wmask", 32'(dmem_req.wmask), 32'(exp_req.wmask));
                if (exp_req.wmask != 4'b0000) begin
                    check_word("store addr", dmem_req.addr, exp_req.addr);
                    check_word("store wdata", dmem_req.wdata, exp_req.wdata);
                end
                retires++;
                if (retires == num_retires) begin
                    $display("Result: PASSED");
                    $finish;
                end
            end else begin
                check_word("fetch addr", imem_addr, ref_pc);
                check_word("wmask in fetch", 32'(dmem_req.wmask), 32'd0);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d instructions retired",
                     cycles, retires, num_retires);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

endmodule

// ==== src/core_top.sv ====
/* rv32i two-phase core */

module core_top #(
    parameter rv_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  logic              clk,
    input  logic              reset,
    output rv_pkg::word_t     imem_addr,
    input  rv_pkg::word_t     imem_rdata,
    output rv_pkg::dmem_req_t dmem_req,
    input  rv_pkg::word_t     dmem_rdata,
    output logic              retire_valid,
    output rv_pkg::retire_t   retire
);
    import rv_pkg::*;

    word_t        pc;
    rv_inst_u     inst;
    logic         exec_valid;
    decoded_t     dec;
    word_t        rs1_data;
    word_t        rs2_data;
    exec_result_t exec;
    logic         wb_we;
    word_t        wb_data;

    fetch_unit #(
        .reset_pc (reset_pc)
    ) fetch_i (
        .clk        (clk),
        .reset      (reset),
        .imem_rdata (imem_rdata),
        .redirect   (exec),
        .pc         (pc),
        .inst       (inst),
        .exec_valid (exec_valid)
    );

    inst_decoder decode_i (
        .inst (inst),
        .dec  (dec)
    );

    reg_file regs_i (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data),
        .we     (wb_we),     // already qualified by exec_valid
        .waddr  (dec.rd),
        .wdata  (wb_data)
    );

    execute_unit exec_i (
        .dec      (dec),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (exec)
    );

    mem_wb_unit mem_wb_i (
        .exec_valid (exec_valid),
        .dec        (dec),
        .pc         (pc),
        .exec       (exec),
        .rs2_data   (rs2_data),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (dmem_req),
        .wb_we      (wb_we),
        .wb_data    (wb_data)
    );

    assign imem_addr    = pc;  // only sampled in the fetch phase
    assign retire_valid = exec_valid;

    always_comb begin
        retire.pc      = pc;
        retire.rd      = dec.rd;
        retire.we      = wb_we;  // before the x0 filter
        retire.wdata   = wb_data;
        retire.next_pc = exec.jump_en ? exec.jump_target : pc + 32'd4;
    end

endmodule

// ==== src/mem_wb_unit.sv ====
/* data memory access and writeback */

module mem_wb_unit (
    input  logic                 exec_valid,
    input  rv_pkg::decoded_t     dec,
    input  rv_pkg::word_t        pc,
    input  rv_pkg::exec_result_t exec,
    input  rv_pkg::word_t        rs2_data,
    input  rv_pkg::word_t        dmem_rdata,
    output rv_pkg::dmem_req_t    dmem_req,
    output logic                 wb_we,
    output rv_pkg::word_t        wb_data
);
    import rv_pkg::*;

    logic [1:0] byte_off;
    logic [3:0] store_mask;
    word_t      lane_data;
    word_t      load_data;

    assign byte_off = exec.alu_result[1:0];

    // store side, data moved into its byte lanes
    always_comb begin
        case (dec.funct3)
            3'b000:  store_mask = 4'b0001 << byte_off;  // sb
            3'b001:  store_mask = 4'b0011 << byte_off;  // sh
            3'b010:  store_mask = 4'b1111;
            default: store_mask = 4'b0000;
        endcase
        dmem_req.addr  = exec.alu_result;
        dmem_req.wdata = rs2_data << {byte_off, 3'b000};
        dmem_req.wmask = (exec_valid && dec.cls == CLS_S) ? store_mask : 4'b0000;
    end

    // dmem_rdata is the whole word holding the address
    assign lane_data = dmem_rdata >> {byte_off, 3'b000};

    always_comb begin
        case (dec.funct3)
            3'b000:  load_data = {{24{lane_data[7]}}, lane_data[7:0]};
            3'b001:  load_data = {{16{lane_data[15]}}, lane_data[15:0]};
            3'b010:  load_data = lane_data;
            3'b100:  load_data = {24'b0, lane_data[7:0]};
            3'b101:  load_data = {16'b0, lane_data[15:0]};
            default: load_data = '0;
        endcase
    end

    always_comb begin
        wb_we   = 1'b0;
        wb_data = '0;
        case (dec.cls)
            CLS_R, CLS_U: begin
                wb_we   = 1'b1;
                wb_data = exec.alu_result;
            end
            CLS_I: begin
                wb_we = 1'b1;
                if (dec.opcode == LOAD) begin
                    wb_data = load_data;
                end else if (dec.opcode == JALR) begin
                    wb_data = pc + 32'd4;  // link address
                end else begin
                    wb_data = exec.alu_result;
                end
            end
            CLS_J: begin
                wb_we   = 1'b1;
                wb_data = pc + 32'd4;
            end
            default: ;  // stores, branches, no-ops
        endcase
        wb_we = wb_we & exec_valid;
    end

endmodule

// ==== src/execute_unit.sv ====
/* execute stage */

module execute_unit (
    input  rv_pkg::decoded_t     dec,
    input  rv_pkg::word_t        pc,
    input  rv_pkg::word_t        rs1_data,
    input  rv_pkg::word_t        rs2_data,
    output rv_pkg::exec_result_t result
);
    import rv_pkg::*;

    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    logic  take_branch;

    alu alu_i (
        .a      (alu_a),
        .b      (alu_b),
        .op     (dec.alu_op),
        .result (alu_result)
    );

    // operand selection per class
    always_comb begin
        alu_a = rs1_data;
        alu_b = dec.imm;
        case (dec.cls)
            CLS_R: alu_b = rs2_data;
            CLS_U: alu_a = (dec.opcode == LUI) ? '0 : pc;  // lui is 0 + imm
            CLS_B, CLS_J: alu_a = pc;  // target adder
            default: ;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  take_branch = (rs1_data == rs2_data);
            3'b001:  take_branch = (rs1_data != rs2_data);
            3'b100:  take_branch = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  take_branch = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  take_branch = (rs1_data < rs2_data);
            3'b111:  take_branch = (rs1_data >= rs2_data);
            default: take_branch = 1'b0;  // 010 / 011 are not branches
        endcase
    end

    always_comb begin
        result.alu_result  = alu_result;
        result.jump_en     = 1'b0;
        result.jump_target = alu_result;
        case (dec.cls)
            CLS_B: result.jump_en = take_branch;
            CLS_J: result.jump_en = 1'b1;
            CLS_I: begin
                if (dec.opcode == JALR) begin
                    result.jump_en     = 1'b1;
                    result.jump_target = {alu_result[xlen-1:1], 1'b0};
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== src/alu.sv ====
/* integer alu */

module alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_e op,
    output rv_pkg::word_t   result
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(xlen-1){1'b0}}, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;  // keeps the sign bit
            ALU_OR:   result = a | b;
            default:  result = a & b;
        endcase
    end

endmodule

// ==== src/reg_file.sv ====
/* general register file */

module reg_file (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2,
    input  logic              we,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::word_t     wdata
);
    import rv_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int n = 0; n < 32; n++) begin
                regs[n] <= '0;
            end
        end else if (we && waddr != '0) begin  // x0 never written
            regs[waddr] <= wdata;
        end
    end

    // combinational read ports
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== src/inst_decoder.sv ====
/* instruction decoder */

module inst_decoder (
    input  rv_pkg::rv_inst_u inst,
    output rv_pkg::decoded_t dec
);
    import rv_pkg::*;

    logic [6:0] funct7;

    assign funct7 = inst.r.funct7;

    always_comb begin
        dec.opcode = opcode_e'(inst.r.opcode);
        dec.funct3 = inst.r.funct3;
        dec.rd     = inst.r.rd;
        dec.rs1    = inst.r.rs1;
        dec.rs2    = inst.r.rs2;

        case (dec.opcode)
            OP:                 dec.cls = CLS_R;
            OP_IMM, LOAD, JALR: dec.cls = CLS_I;
            STORE:              dec.cls = CLS_S;
            BRANCH:             dec.cls = CLS_B;
            LUI, AUIPC:         dec.cls = CLS_U;
            JAL:                dec.cls = CLS_J;
            default:            dec.cls = CLS_N;  // system and unknown opcodes
        endcase

        // sign-extended immediate, read through the matching format view
        case (dec.cls)
            CLS_I: dec.imm = {{20{inst.i.imm[11]}}, inst.i.imm};
            CLS_S: dec.imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            CLS_B: begin
                dec.imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                           inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            end
            CLS_U: dec.imm = {inst.u.imm, 12'b0};
            CLS_J: begin
                dec.imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                           inst.j.imm_11, inst.j.imm_10_1, 1'b0};
            end
            default: dec.imm = '0;
        endcase

        // everything outside OP / OP_IMM uses the adder
        dec.alu_op = ALU_ADD;
        if (dec.opcode == OP || dec.opcode == OP_IMM) begin
            case (dec.funct3)
                3'b000: dec.alu_op = (dec.cls == CLS_R && funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001: dec.alu_op = ALU_SLL;
                3'b010: dec.alu_op = ALU_SLT;
                3'b011: dec.alu_op = ALU_SLTU;
                3'b100: dec.alu_op = ALU_XOR;
                3'b101: dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;  // also srai via imm[10]
                3'b110: dec.alu_op = ALU_OR;
                default: dec.alu_op = ALU_AND;
            endcase
        end
    end

endmodule

// ==== src/fetch_unit.sv ====
/* pc and instruction fetch */

module fetch_unit #(
    parameter rv_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_pkg::word_t        imem_rdata,
    input  rv_pkg::exec_result_t redirect,
    output rv_pkg::word_t        pc,
    output rv_pkg::rv_inst_u     inst,
    output logic                 exec_valid
);
    import rv_pkg::*;

    word_t seq_pc;

    assign seq_pc = pc + 32'd4;

    // phase toggles every cycle: fetch, execute, fetch ...
    always_ff @(posedge clk) begin
        if (reset) begin
            exec_valid <= 1'b0;
        end else begin
            exec_valid <= ~exec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (exec_valid) begin
            pc <= redirect.jump_en ? redirect.jump_target : seq_pc;  // end of execute
        end
    end

    // imem answers in the fetch cycle itself
    always_ff @(posedge clk) begin
        if (!exec_valid) begin
            inst <= imem_rdata;
        end
    end

endmodule

// ==== src/rv_pkg.sv ====
/* rv32i core shared types */

package rv_pkg;

    parameter int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        CLS_R,
        CLS_I,
        CLS_S,
        CLS_B,
        CLS_U,
        CLS_J,
        CLS_N  // no operands, retires as a no-op
    } inst_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } rv_inst_u;

    typedef struct packed {
        opcode_e     opcode;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        word_t       imm;
        inst_class_e cls;
        alu_op_e     alu_op;
    } decoded_t;

    typedef struct packed {
        word_t alu_result;
        logic  jump_en;
        word_t jump_target;
    } exec_result_t;

    typedef struct packed {
        word_t      addr;   // byte address
        word_t      wdata;  // already shifted into its lanes
        logic [3:0] wmask;  // zero means no write
    } dmem_req_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        logic      we;
        word_t     wdata;
        word_t     next_pc;
    } retire_t;

endpackage
